/* src.f */
source/msched_pkg.sv
source/msched_regfile.sv
source/x_tile_walker.sv
source/stream_cfg_gen.sv
source/gidx_offset_unit.sv
source/memory_scheduler.sv
dv/memory_scheduler_properties.sv
dv/tb_memory_scheduler.sv

/* Makefile */
# Verilator build for the memory scheduler testbench

VERILATOR   ?= verilator
TOP         ?= tb_memory_scheduler
BUILD_DIR   ?= obj_dir
FILELIST    ?= src.f
VFLAGS      ?= --binary --timing --assert -Wno-fatal
EXTRA_FLAGS ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* dv/tb_memory_scheduler.sv */
`timescale 1ns/1ps

module tb_memory_scheduler;

  localparam time         CLK_PERIOD = 8ns;
  localparam int unsigned MAX_WAIT   = 50;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          clear_i;
  logic                          reg_we_i;
  logic [msched_pkg::REG_AW-1:0] reg_addr_i;
  logic [msched_pkg::MEM_DW-1:0] reg_wdata_i;
  logic                          first_load_i;
  msched_pkg::sched_flags_t      flags_i;
  msched_pkg::sched_ctrl_t       ctrl_o;
  logic                          gidx_valid_i;
  msched_pkg::gidx_beat_t        gidx_i;
  logic                          gidx_ready_o;
  logic                          scales_ready_i;
  logic                          zeros_ready_i;
  logic                          offs_valid_o;
  msched_pkg::offs_beat_t        scales_offs_o;
  msched_pkg::offs_beat_t        zeros_offs_o;

  // Reference state, follows the same clock edges as the DUT
  logic [15:0][31:0] shadow_q;
  int unsigned       cols_q;
  int unsigned       w_q;
  int unsigned       rows_q;
  int unsigned       loads_q;
  string             test_name;

  memory_scheduler u_memory_scheduler (.*);

  bind memory_scheduler memory_scheduler_properties u_props (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .first_load_i   (first_load_i),
    .scales_ready_i (scales_ready_i),
    .zeros_ready_i  (zeros_ready_i),
    .offs_valid_o   (offs_valid_o),
    .flags_i        (flags_i),
    .ctrl_o         (ctrl_o),
    .job_i          (job),
    .x_pos_i        (x_pos)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic msched_pkg::addrgen_cfg_t ref_x_cfg(logic [15:0][31:0] r,
                                                         int unsigned cols, int unsigned rows);
    msched_pkg::addrgen_cfg_t c;
    logic [7:0]               left;
    left = r[msched_pkg::LEFTOVERS][31:24];
    c = '0;
    c.base_addr = r[msched_pkg::X_ADDR] + cols * msched_pkg::X_COL_JMP +
                  rows * r[msched_pkg::X_ROWS_OFFS];
    // Leftover rows shorten only the last row tile
    if (rows + 1 == 32'(r[msched_pkg::X_ITERS][31:16]) && left != 8'd0) begin
      c.tot_len = 32'(left);
    end else begin
      c.tot_len = msched_pkg::ARRAY_W;
    end
    c.d0_len        = 32'd1;
    c.d1_len        = msched_pkg::ARRAY_W;
    c.d1_stride     = r[msched_pkg::X_D1_STRIDE];
    c.dim_enable_1h = 3'b011;
    return c;
  endfunction

  function automatic msched_pkg::addrgen_cfg_t ref_w_cfg(logic [15:0][31:0] r);
    msched_pkg::addrgen_cfg_t c;
    logic                     deq;
    deq = r[msched_pkg::MODE_CFG][0];
    c = '0;
    c.base_addr     = deq ? r[msched_pkg::SCALES_ADDR] : r[msched_pkg::W_ADDR];
    c.tot_len       = r[msched_pkg::W_TOT_LEN];
    c.d0_len        = 32'(r[msched_pkg::W_ITERS][31:16]);
    c.d0_stride     = deq ? 32'd0 : r[msched_pkg::W_D0_STRIDE];
    c.d1_len        = 32'(r[msched_pkg::W_ITERS][15:0]);
    c.d1_stride     = msched_pkg::X_COL_JMP;
    c.dim_enable_1h = 3'b011;
    return c;
  endfunction

  function automatic msched_pkg::addrgen_cfg_t ref_z_cfg(logic [15:0][31:0] r);
    msched_pkg::addrgen_cfg_t c;
    c = '0;
    c.base_addr     = r[msched_pkg::Z_ADDR];
    c.tot_len       = r[msched_pkg::Z_TOT_LEN];
    c.d0_len        = msched_pkg::ARRAY_W;
    c.d0_stride     = r[msched_pkg::Z_D0_STRIDE];
    c.d1_len        = 32'(r[msched_pkg::W_ITERS][15:0]);
    c.d1_stride     = msched_pkg::X_COL_JMP;
    c.d2_stride     = r[msched_pkg::Z_D2_STRIDE];
    c.dim_enable_1h = 3'b011;
    return c;
  endfunction

  function automatic msched_pkg::offs_beat_t ref_offs(logic [15:0][31:0] r,
                                                      msched_pkg::gidx_beat_t b, logic zeros);
    msched_pkg::offs_beat_t o;
    logic [15:0]            stride;
    stride = r[msched_pkg::W_D0_STRIDE][15:0];
    if (zeros) begin
      case (r[msched_pkg::MODE_CFG][2:1])
        2'b10:   stride = stride >> 3;
        2'b01:   stride = stride >> 2;
        default: stride = stride >> 1;
      endcase
    end
    o.skip = b.skip;
    o.bias = 32'(b.idx) * 32'(stride);
    return o;
  endfunction

  task automatic stop_with_failure(string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_cfg(string what, msched_pkg::addrgen_cfg_t exp,
                           msched_pkg::addrgen_cfg_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAILED %s: %s expected %h actual %h",
                                  test_name, what, exp, act));
    end
  endtask

  task automatic check_offs(string what, msched_pkg::offs_beat_t exp,
                            msched_pkg::offs_beat_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAILED %s: %s expected %h actual %h",
                                  test_name, what, exp, act));
    end
  endtask

  task automatic check_bit(string what, logic exp, logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAILED %s: %s expected %b actual %b",
                                  test_name, what, exp, act));
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin : reference_model
    if (!rst_ni) begin
      shadow_q <= '0;
      cols_q   <= 0;
      w_q      <= 0;
      rows_q   <= 0;
      loads_q  <= 0;
    end else begin
      if (reg_we_i) begin
        shadow_q[reg_addr_i] <= reg_wdata_i;
      end
      if (clear_i) begin
        cols_q  <= 0;
        w_q     <= 0;
        rows_q  <= 0;
        loads_q <= 0;
      end else if (flags_i.x_src.done) begin
        loads_q <= loads_q + 1;
        // Columns innermost, then W, then rows
        if (cols_q + 1 < 32'(shadow_q[msched_pkg::X_ITERS][15:0])) begin
          cols_q <= cols_q + 1;
        end else begin
          cols_q <= 0;
          if (w_q + 1 < 32'(shadow_q[msched_pkg::W_ITERS][15:0])) begin
            w_q <= w_q + 1;
          end else begin
            w_q    <= 0;
            rows_q <= (rows_q + 1 < 32'(shadow_q[msched_pkg::X_ITERS][31:16])) ? rows_q + 1 : 0;
          end
        end
      end
    end
  end

  // Outputs are compared mid-cycle, well away from the input changes
  always @(negedge clk_i) begin : compare_outputs
    logic reload;
    logic deq;
    logic both_ready;
    if (rst_ni) begin
      reload     = loads_q != 0 && loads_q != shadow_q[msched_pkg::TOT_X_READ];
      deq        = shadow_q[msched_pkg::MODE_CFG][0];
      both_ready = scales_ready_i && zeros_ready_i;
      check_cfg("x cfg", ref_x_cfg(shadow_q, cols_q, rows_q), ctrl_o.x_src.addrgen);
      check_cfg("w cfg", ref_w_cfg(shadow_q), ctrl_o.w_src.addrgen);
      check_cfg("z cfg", ref_z_cfg(shadow_q), ctrl_o.z_snk.addrgen);
      check_bit("x start", (first_load_i || reload) && flags_i.x_src.ready_start,
                ctrl_o.x_src.req_start);
      check_bit("w start", first_load_i && flags_i.w_src.ready_start, ctrl_o.w_src.req_start);
      check_bit("z start", first_load_i && flags_i.z_snk.ready_start, ctrl_o.z_snk.req_start);
      check_bit("x ignore_bias", 1'b1, ctrl_o.x_src.ignore_bias);
      check_bit("x ignore_skip", 1'b1, ctrl_o.x_src.ignore_skip);
      check_bit("z ignore_bias", 1'b1, ctrl_o.z_snk.ignore_bias);
      check_bit("z ignore_skip", 1'b1, ctrl_o.z_snk.ignore_skip);
      check_bit("w ignore_bias", !deq, ctrl_o.w_src.ignore_bias);
      check_bit("w ignore_skip", !deq, ctrl_o.w_src.ignore_skip);
      check_bit("gidx ready", both_ready, gidx_ready_o);
      check_bit("offs valid", gidx_valid_i && both_ready, offs_valid_o);
      if (offs_valid_o) begin
        check_offs("scales offs", ref_offs(shadow_q, gidx_i, 1'b0), scales_offs_o);
        check_offs("zeros offs", ref_offs(shadow_q, gidx_i, 1'b1), zeros_offs_o);
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic write_reg(int unsigned addr, logic [31:0] data);
    reg_we_i    = 1'b1;
    reg_addr_i  = msched_pkg::REG_AW'(addr);
    reg_wdata_i = data;
    next_cycle();
    reg_we_i    = 1'b0;
  endtask

  task automatic pulse_clear();
    clear_i = 1'b1;
    next_cycle();
    clear_i = 1'b0;
  endtask

  task automatic randomize_flags();
    flags_i.x_src.ready_start = 1'($urandom());
    flags_i.w_src.ready_start = 1'($urandom());
    flags_i.z_snk.ready_start = 1'($urandom());
    first_load_i              = $urandom_range(0, 3) == 0;
  endtask

  task automatic drive_readies();
    scales_ready_i = $urandom_range(0, 3) != 0;
    zeros_ready_i  = $urandom_range(0, 3) != 0;
  endtask

  task automatic load_job(logic deq);
    int unsigned cols;
    int unsigned ws;
    int unsigned rows;
    cols = $urandom_range(1, 3);
    ws   = $urandom_range(1, 3);
    rows = $urandom_range(1, 3);
    pulse_clear();
    write_reg(msched_pkg::X_ADDR, $urandom());
    write_reg(msched_pkg::W_ADDR, $urandom());
    write_reg(msched_pkg::Z_ADDR, $urandom());
    write_reg(msched_pkg::SCALES_ADDR, $urandom());
    write_reg(msched_pkg::X_ITERS, {16'(rows), 16'(cols)});
    write_reg(msched_pkg::W_ITERS, {16'($urandom()), 16'(ws)});
    write_reg(msched_pkg::LEFTOVERS, {8'($urandom_range(0, 7)), 24'($urandom())});
    write_reg(msched_pkg::TOT_X_READ, cols * ws * rows);
    for (int unsigned a = msched_pkg::X_ROWS_OFFS; a < msched_pkg::MODE_CFG; a++) begin
      write_reg(a, $urandom());
    end
    write_reg(msched_pkg::MODE_CFG,
              {28'($urandom()), 1'($urandom()), 2'($urandom_range(0, 2)), deq});
  endtask

  task automatic walk(int unsigned pulses);
    for (int unsigned n = 0; n < pulses; n++) begin
      randomize_flags();
      flags_i.x_src.done = 1'b1;
      next_cycle();
      flags_i.x_src.done = 1'b0;
      repeat ($urandom_range(0, 3)) begin
        randomize_flags();
        next_cycle();
      end
    end
  endtask

  task automatic send_beat();
    int unsigned waited;
    waited         = 0;
    gidx_valid_i   = 1'b1;
    gidx_i.skip    = 1'($urandom());
    gidx_i.idx     = msched_pkg::GIDX_W'($urandom());
    drive_readies();
    #1;
    while (!gidx_ready_o) begin
      if (waited == MAX_WAIT) begin
        stop_with_failure("Timeout: group-index beat was never accepted");
      end
      waited++;
      next_cycle();
      drive_readies();
      #1;
    end
    next_cycle();
    gidx_valid_i = 1'b0;
  endtask

  initial begin : stimulus
    void'($urandom(29));
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    reg_we_i       = 1'b0;
    reg_addr_i     = '0;
    reg_wdata_i    = '0;
    first_load_i   = 1'b0;
    flags_i        = '0;
    gidx_valid_i   = 1'b0;
    gidx_i         = '0;
    scales_ready_i = 1'b0;
    zeros_ready_i  = 1'b0;
    test_name      = "reset";
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_name = "cfg_plain";
    load_job(1'b0);
    repeat (4) next_cycle();

    test_name = "cfg_dequant";
    load_job(1'b1);
    repeat (4) next_cycle();

    test_name = "walk";
    load_job(1'($urandom()));
    walk($urandom_range(1, shadow_q[msched_pkg::TOT_X_READ] + 4));

    // Once the job total is read, only first_load can restart X
    test_name = "start_rule";
    load_job(1'b0);
    walk(shadow_q[msched_pkg::TOT_X_READ]);
    flags_i.x_src.ready_start = 1'b1;
    flags_i.w_src.ready_start = 1'b1;
    flags_i.z_snk.ready_start = 1'b1;
    first_load_i              = 1'b0;
    #1;
    check_bit("x start after total", 1'b0, ctrl_o.x_src.req_start);
    check_bit("w start without first_load", 1'b0, ctrl_o.w_src.req_start);
    next_cycle();
    first_load_i = 1'b1;
    #1;
    check_bit("x start with first_load", 1'b1, ctrl_o.x_src.req_start);
    check_bit("z start with first_load", 1'b1, ctrl_o.z_snk.req_start);
    next_cycle();
    first_load_i = 1'b0;

    test_name = "offsets";
    for (int unsigned fmt = 0; fmt < 3; fmt++) begin
      write_reg(msched_pkg::MODE_CFG, {29'd0, 2'(fmt), 1'b1});
      write_reg(msched_pkg::W_D0_STRIDE, $urandom());
      repeat (8) send_beat();
    end

    test_name = "clear";
    load_job(1'b0);
    write_reg(msched_pkg::X_ITERS, {16'd3, 16'd2});
    walk(3);
    pulse_clear();
    #1;
    check_cfg("x cfg after clear", ref_x_cfg(shadow_q, 0, 0), ctrl_o.x_src.addrgen);
    repeat (2) next_cycle();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* dv/memory_scheduler_properties.sv */
`timescale 1ns/1ps

module memory_scheduler_properties (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     clear_i,
  input logic                     first_load_i,
  input logic                     scales_ready_i,
  input logic                     zeros_ready_i,
  input logic                     offs_valid_o,
  input msched_pkg::sched_flags_t flags_i,
  input msched_pkg::sched_ctrl_t  ctrl_o,
  input msched_pkg::job_params_t  job_i,
  input msched_pkg::x_pos_t       x_pos_i
);

  // Offsets only leave when both sinks accept
  offs_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    offs_valid_o |-> (scales_ready_i && zeros_ready_i))
    else $error("offs_valid_o high while a ready is low");

  x_start_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl_o.x_src.req_start |-> flags_i.x_src.ready_start)
    else $error("x req_start high without X ready_start");

  wz_start_needs_first_load: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ctrl_o.w_src.req_start || ctrl_o.z_snk.req_start) |-> first_load_i)
    else $error("w or z req_start high without first_load_i");

  // Walker is back at the origin one cycle after a clear
  clear_resets_x_base: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> (x_pos_i.x_base_offs == '0) &&
                (ctrl_o.x_src.addrgen.base_addr == job_i.x_addr))
    else $error("X base differs from X_ADDR after clear");

endmodule

/* source/memory_scheduler.sv */
`timescale 1ns/1ps

module memory_scheduler (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          reg_we_i,
  input  logic [msched_pkg::REG_AW-1:0] reg_addr_i,
  input  logic [msched_pkg::MEM_DW-1:0] reg_wdata_i,
  input  logic                          first_load_i,
  input  msched_pkg::sched_flags_t      flags_i,
  output msched_pkg::sched_ctrl_t       ctrl_o,
  input  logic                          gidx_valid_i,
  input  msched_pkg::gidx_beat_t        gidx_i,
  output logic                          gidx_ready_o,
  input  logic                          scales_ready_i,
  input  logic                          zeros_ready_i,
  output logic                          offs_valid_o,
  output msched_pkg::offs_beat_t        scales_offs_o,
  output msched_pkg::offs_beat_t        zeros_offs_o
);

  msched_pkg::job_params_t job;
  msched_pkg::x_pos_t      x_pos;

  msched_regfile u_regfile (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .job_o       (job)
  );

  x_tile_walker u_walker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .x_done_i (flags_i.x_src.done),
    .job_i    (job),
    .x_pos_o  (x_pos)
  );

  stream_cfg_gen u_cfg_gen (
    .job_i        (job),
    .x_pos_i      (x_pos),
    .first_load_i (first_load_i),
    .flags_i      (flags_i),
    .ctrl_o       (ctrl_o)
  );

  gidx_offset_unit u_offs (
    .job_i          (job),
    .gidx_valid_i   (gidx_valid_i),
    .gidx_i         (gidx_i),
    .gidx_ready_o   (gidx_ready_o),
    .scales_ready_i (scales_ready_i),
    .zeros_ready_i  (zeros_ready_i),
    .offs_valid_o   (offs_valid_o),
    .scales_offs_o  (scales_offs_o),
    .zeros_offs_o   (zeros_offs_o)
  );

endmodule

/* source/gidx_offset_unit.sv */
`timescale 1ns/1ps

module gidx_offset_unit (
  input  msched_pkg::job_params_t job_i,
  input  logic                    gidx_valid_i,
  input  msched_pkg::gidx_beat_t  gidx_i,
  output logic                    gidx_ready_o,
  input  logic                    scales_ready_i,
  input  logic                    zeros_ready_i,
  output logic                    offs_valid_o,
  output msched_pkg::offs_beat_t  scales_offs_o,
  output msched_pkg::offs_beat_t  zeros_offs_o
);

  logic                          both_ready;
  logic [msched_pkg::HALF_W-1:0] scales_stride;
  logic [msched_pkg::HALF_W-1:0] zeros_stride;
  logic [msched_pkg::MEM_DW-1:0] idx_word;
  logic [msched_pkg::MEM_DW-1:0] scales_bias;
  logic [msched_pkg::MEM_DW-1:0] zeros_bias;

  // A beat moves only when both offset sinks can take it
  assign both_ready   = scales_ready_i && zeros_ready_i;
  assign gidx_ready_o = both_ready;
  assign offs_valid_o = gidx_valid_i && both_ready;

  // Scales are one entry per W column step
  assign scales_stride = job_i.w_d0_stride[msched_pkg::HALF_W-1:0];

  // Zeros are packed, so their stride shrinks with the format
  assign zeros_stride = scales_stride >> job_i.q_shift;

  assign idx_word = msched_pkg::MEM_DW'(gidx_i.idx);

  assign scales_bias = idx_word * msched_pkg::MEM_DW'(scales_stride);
  assign zeros_bias  = idx_word * msched_pkg::MEM_DW'(zeros_stride);

  always_comb begin
    scales_offs_o.skip = gidx_i.skip;
    scales_offs_o.bias = scales_bias;
  end

  always_comb begin
    zeros_offs_o.skip = gidx_i.skip;
    zeros_offs_o.bias = zeros_bias;
  end

endmodule

/* source/stream_cfg_gen.sv */
`timescale 1ns/1ps

module stream_cfg_gen (
  input  msched_pkg::job_params_t  job_i,
  input  msched_pkg::x_pos_t       x_pos_i,
  input  logic                     first_load_i,
  input  msched_pkg::sched_flags_t flags_i,
  output msched_pkg::sched_ctrl_t  ctrl_o
);

  localparam logic [msched_pkg::MEM_DW-1:0] ColJmp  = msched_pkg::MEM_DW'(msched_pkg::X_COL_JMP);
  localparam logic [msched_pkg::MEM_DW-1:0] ArrayW  = msched_pkg::MEM_DW'(msched_pkg::ARRAY_W);

  logic [msched_pkg::MEM_DW-1:0] w_iters_word;

  assign w_iters_word = msched_pkg::MEM_DW'(job_i.w_iters);

  // X source walks one tile of rows per load
  always_comb begin
    ctrl_o.x_src.addrgen.base_addr     = job_i.x_addr + x_pos_i.x_base_offs;
    ctrl_o.x_src.addrgen.tot_len       = msched_pkg::MEM_DW'(x_pos_i.x_num_reads);
    ctrl_o.x_src.addrgen.d0_len        = 32'd1;
    ctrl_o.x_src.addrgen.d0_stride     = '0;
    ctrl_o.x_src.addrgen.d1_len        = ArrayW;
    ctrl_o.x_src.addrgen.d1_stride     = job_i.x_d1_stride;
    ctrl_o.x_src.addrgen.d2_stride     = '0;
    ctrl_o.x_src.addrgen.dim_enable_1h = 3'b011;
    ctrl_o.x_src.ignore_bias           = 1'b1;
    ctrl_o.x_src.ignore_skip           = 1'b1;
  end

  // In dequant mode W fetches the scales, offset by group index
  always_comb begin
    ctrl_o.w_src.addrgen.base_addr     = job_i.dequant_en ? job_i.scales_addr : job_i.w_addr;
    ctrl_o.w_src.addrgen.tot_len       = job_i.w_tot_len;
    ctrl_o.w_src.addrgen.d0_len        = msched_pkg::MEM_DW'(job_i.w_depth_len);
    ctrl_o.w_src.addrgen.d0_stride     = job_i.dequant_en ? '0 : job_i.w_d0_stride;
    ctrl_o.w_src.addrgen.d1_len        = w_iters_word;
    ctrl_o.w_src.addrgen.d1_stride     = ColJmp;
    ctrl_o.w_src.addrgen.d2_stride     = '0;
    ctrl_o.w_src.addrgen.dim_enable_1h = 3'b011;
    ctrl_o.w_src.ignore_bias           = !job_i.dequant_en;
    ctrl_o.w_src.ignore_skip           = !job_i.dequant_en;
  end

  always_comb begin
    ctrl_o.z_snk.addrgen.base_addr     = job_i.z_addr;
    ctrl_o.z_snk.addrgen.tot_len       = job_i.z_tot_len;
    ctrl_o.z_snk.addrgen.d0_len        = ArrayW;
    ctrl_o.z_snk.addrgen.d0_stride     = job_i.z_d0_stride;
    ctrl_o.z_snk.addrgen.d1_len        = w_iters_word;
    ctrl_o.z_snk.addrgen.d1_stride     = ColJmp;
    ctrl_o.z_snk.addrgen.d2_stride     = job_i.z_d2_stride;
    ctrl_o.z_snk.addrgen.dim_enable_1h = 3'b011;
    ctrl_o.z_snk.ignore_bias           = 1'b1;
    ctrl_o.z_snk.ignore_skip           = 1'b1;
  end

  // X restarts on every reload until the job total is reached
  assign ctrl_o.x_src.req_start = (first_load_i || x_pos_i.x_reload) &&
                                  flags_i.x_src.ready_start;
  assign ctrl_o.w_src.req_start = first_load_i && flags_i.w_src.ready_start;
  assign ctrl_o.z_snk.req_start = first_load_i && flags_i.z_snk.ready_start;

endmodule

/* source/x_tile_walker.sv */
`timescale 1ns/1ps

module x_tile_walker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    x_done_i,
  input  msched_pkg::job_params_t job_i,
  output msched_pkg::x_pos_t      x_pos_o
);

  logic [msched_pkg::HALF_W-1:0] cols_iter_q;
  logic [msched_pkg::HALF_W-1:0] w_iter_q;
  logic [msched_pkg::HALF_W-1:0] rows_iter_q;
  logic [msched_pkg::MEM_DW-1:0] cols_offs_q;
  logic [msched_pkg::MEM_DW-1:0] rows_offs_q;
  logic [msched_pkg::MEM_DW-1:0] tot_read_q;

  logic cols_last;
  logic w_last;
  logic rows_last;
  logic cols_wrap;
  logic w_wrap;

  assign cols_last = cols_iter_q == job_i.x_cols_iters - 16'd1;
  assign w_last    = w_iter_q == job_i.w_iters - 16'd1;
  assign rows_last = rows_iter_q == job_i.x_rows_iters - 16'd1;

  // Nested wrap conditions, columns innermost
  assign cols_wrap = x_done_i && cols_last;
  assign w_wrap    = cols_wrap && w_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cols_iter_q <= '0;
      cols_offs_q <= '0;
    end else if (clear_i) begin
      cols_iter_q <= '0;
      cols_offs_q <= '0;
    end else if (x_done_i) begin
      if (cols_last) begin
        cols_iter_q <= '0;
        cols_offs_q <= '0;
      end else begin
        cols_iter_q <= cols_iter_q + 16'd1;
        cols_offs_q <= cols_offs_q + msched_pkg::MEM_DW'(msched_pkg::X_COL_JMP);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_iter_q <= '0;
    end else if (clear_i) begin
      w_iter_q <= '0;
    end else if (cols_wrap) begin
      w_iter_q <= w_last ? '0 : w_iter_q + 16'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_iter_q <= '0;
      rows_offs_q <= '0;
    end else if (clear_i) begin
      rows_iter_q <= '0;
      rows_offs_q <= '0;
    end else if (w_wrap) begin
      if (rows_last) begin
        rows_iter_q <= '0;
        rows_offs_q <= '0;
      end else begin
        rows_iter_q <= rows_iter_q + 16'd1;
        rows_offs_q <= rows_offs_q + job_i.x_rows_offs;
      end
    end
  end

  // Tile loads completed so far in this job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tot_read_q <= '0;
    end else if (clear_i) begin
      tot_read_q <= '0;
    end else if (x_done_i) begin
      tot_read_q <= tot_read_q + 32'd1;
    end
  end

  assign x_pos_o.x_base_offs = cols_offs_q + rows_offs_q;

  // Last row tile may be shorter than the array
  assign x_pos_o.x_num_reads = (rows_last && job_i.leftover_rows != 8'd0) ?
                               job_i.leftover_rows[msched_pkg::NUM_READS_W-1:0] :
                               msched_pkg::NUM_READS_W'(msched_pkg::ARRAY_W);

  assign x_pos_o.x_reload = tot_read_q != '0 && tot_read_q != job_i.tot_x_read;

endmodule

/* source/msched_regfile.sv */
`timescale 1ns/1ps

module msched_regfile (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           reg_we_i,
  input  logic [msched_pkg::REG_AW-1:0]  reg_addr_i,
  input  logic [msched_pkg::MEM_DW-1:0]  reg_wdata_i,
  output msched_pkg::job_params_t        job_o
);

  logic [msched_pkg::MEM_DW-1:0] regs_q [msched_pkg::NUM_REGS];

  logic [msched_pkg::MEM_DW-1:0] mode_word;
  msched_pkg::qint_fmt_e         qint_fmt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '{default: '0};
    end else if (reg_we_i) begin
      regs_q[reg_addr_i] <= reg_wdata_i;
    end
  end

  assign mode_word = regs_q[msched_pkg::MODE_CFG];
  assign qint_fmt  = msched_pkg::qint_fmt_e'(mode_word[2:1]);

  always_comb begin
    job_o.x_addr      = regs_q[msched_pkg::X_ADDR];
    job_o.w_addr      = regs_q[msched_pkg::W_ADDR];
    job_o.z_addr      = regs_q[msched_pkg::Z_ADDR];
    job_o.scales_addr = regs_q[msched_pkg::SCALES_ADDR];

    // Iteration words are split in halves
    job_o.x_cols_iters = regs_q[msched_pkg::X_ITERS][msched_pkg::HALF_W-1:0];
    job_o.x_rows_iters = regs_q[msched_pkg::X_ITERS][msched_pkg::MEM_DW-1:msched_pkg::HALF_W];
    job_o.w_iters      = regs_q[msched_pkg::W_ITERS][msched_pkg::HALF_W-1:0];
    job_o.w_depth_len  = regs_q[msched_pkg::W_ITERS][msched_pkg::MEM_DW-1:msched_pkg::HALF_W];

    job_o.leftover_rows = regs_q[msched_pkg::LEFTOVERS][msched_pkg::MEM_DW-1 -: 8];

    job_o.tot_x_read  = regs_q[msched_pkg::TOT_X_READ];
    job_o.x_rows_offs = regs_q[msched_pkg::X_ROWS_OFFS];
    job_o.x_d1_stride = regs_q[msched_pkg::X_D1_STRIDE];
    job_o.w_tot_len   = regs_q[msched_pkg::W_TOT_LEN];
    job_o.w_d0_stride = regs_q[msched_pkg::W_D0_STRIDE];
    job_o.z_tot_len   = regs_q[msched_pkg::Z_TOT_LEN];
    job_o.z_d0_stride = regs_q[msched_pkg::Z_D0_STRIDE];
    job_o.z_d2_stride = regs_q[msched_pkg::Z_D2_STRIDE];

    job_o.dequant_en = mode_word[0];
    job_o.qint_fmt   = qint_fmt;

    // Narrower formats pack more values per byte
    case (qint_fmt)
      msched_pkg::QINT_2: job_o.q_shift = 2'd3;
      msched_pkg::QINT_4: job_o.q_shift = 2'd2;
      default:            job_o.q_shift = 2'd1;
    endcase
  end

endmodule

/* source/msched_pkg.sv */
package msched_pkg;

  // Bus and memory geometry
  localparam int unsigned DATA_W         = 256;
  localparam int unsigned MEM_DW         = 32;
  localparam int unsigned HALF_W         = MEM_DW / 2;
  localparam int unsigned BYTES_PER_WORD = MEM_DW / 8;
  localparam int unsigned X_COL_JMP      = BYTES_PER_WORD * (DATA_W / MEM_DW);
  localparam int unsigned ARRAY_W        = 8;
  localparam int unsigned NUM_READS_W    = $clog2(ARRAY_W) + 1;
  localparam int unsigned GIDX_W         = 16;

  // Job register file
  localparam int unsigned NUM_REGS = 16;
  localparam int unsigned REG_AW   = 4;

  localparam int unsigned X_ADDR      = 0;
  localparam int unsigned W_ADDR      = 1;
  localparam int unsigned Z_ADDR      = 2;
  localparam int unsigned SCALES_ADDR = 3;
  // Low half column iterations, high half row iterations
  localparam int unsigned X_ITERS     = 4;
  // Low half W iterations, high half W depth length
  localparam int unsigned W_ITERS     = 5;
  // Leftover rows in the top byte
  localparam int unsigned LEFTOVERS   = 6;
  localparam int unsigned TOT_X_READ  = 7;
  localparam int unsigned X_ROWS_OFFS = 8;
  localparam int unsigned X_D1_STRIDE = 9;
  localparam int unsigned W_TOT_LEN   = 10;
  localparam int unsigned W_D0_STRIDE = 11;
  localparam int unsigned Z_TOT_LEN   = 12;
  localparam int unsigned Z_D0_STRIDE = 13;
  localparam int unsigned Z_D2_STRIDE = 14;
  // Bit 0 dequant enable, bits 2:1 integer format, bit 3 Y accumulation
  localparam int unsigned MODE_CFG    = 15;

  typedef enum logic [1:0] {
    QINT_8 = 2'b00,
    QINT_4 = 2'b01,
    QINT_2 = 2'b10
  } qint_fmt_e;

  typedef struct packed {
    logic [MEM_DW-1:0] base_addr;
    logic [MEM_DW-1:0] tot_len;
    logic [MEM_DW-1:0] d0_len;
    logic [MEM_DW-1:0] d0_stride;
    logic [MEM_DW-1:0] d1_len;
    logic [MEM_DW-1:0] d1_stride;
    logic [MEM_DW-1:0] d2_stride;
    logic [2:0]        dim_enable_1h;
  } addrgen_cfg_t;

  typedef struct packed {
    logic [MEM_DW-1:0] x_addr;
    logic [MEM_DW-1:0] w_addr;
    logic [MEM_DW-1:0] z_addr;
    logic [MEM_DW-1:0] scales_addr;
    logic [HALF_W-1:0] x_rows_iters;
    logic [HALF_W-1:0] x_cols_iters;
    logic [HALF_W-1:0] w_depth_len;
    logic [HALF_W-1:0] w_iters;
    logic [7:0]        leftover_rows;
    logic [MEM_DW-1:0] tot_x_read;
    logic [MEM_DW-1:0] x_rows_offs;
    logic [MEM_DW-1:0] x_d1_stride;
    logic [MEM_DW-1:0] w_tot_len;
    logic [MEM_DW-1:0] w_d0_stride;
    logic [MEM_DW-1:0] z_tot_len;
    logic [MEM_DW-1:0] z_d0_stride;
    logic [MEM_DW-1:0] z_d2_stride;
    logic              dequant_en;
    qint_fmt_e         qint_fmt;
    logic [1:0]        q_shift;
  } job_params_t;

  typedef struct packed {
    logic ready_start;
    logic done;
  } stream_flags_t;

  typedef struct packed {
    stream_flags_t x_src;
    stream_flags_t w_src;
    stream_flags_t z_snk;
  } sched_flags_t;

  typedef struct packed {
    logic         req_start;
    addrgen_cfg_t addrgen;
    logic         ignore_bias;
    logic         ignore_skip;
  } stream_ctrl_t;

  typedef struct packed {
    stream_ctrl_t x_src;
    stream_ctrl_t w_src;
    stream_ctrl_t z_snk;
  } sched_ctrl_t;

  typedef struct packed {
    logic [MEM_DW-1:0]      x_base_offs;
    logic [NUM_READS_W-1:0] x_num_reads;
    logic                   x_reload;
  } x_pos_t;

  typedef struct packed {
    logic              skip;
    logic [GIDX_W-1:0] idx;
  } gidx_beat_t;

  typedef struct packed {
    logic              skip;
    logic [MEM_DW-1:0] bias;
  } offs_beat_t;

endpackage
